// File: src.f
+incdir+rtl
+incdir+verif
rtl/cia_bus_pkg.sv
rtl/cia_timer_pkg.sv
rtl/cia_bus_regs.sv
rtl/cia_timer.sv
rtl/cia_irq_ctrl.sv
rtl/cia_top.sv
verif/cia_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/100ps
TOP       = cia_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/cia_tests.svh
// Directed tests for the ports and PC strobe, timer A continuous and one-shot,
// timer B cascade, interrupt mask with FLAG and the PB6 toggle output

task automatic port_io();
  logic [7:0] pra;
  logic [7:0] ddra;
  logic [7:0] prb;
  logic [7:0] ddrb;
  logic [7:0] data;
  pra  = 8'($urandom);
  ddra = 8'($urandom);
  prb  = 8'($urandom);
  ddrb = 8'($urandom);
  bus_write(`CIA_REG_DDRA, ddra);
  bus_write(`CIA_REG_PRA, pra);
  bus_write(`CIA_REG_DDRB, ddrb);
  bus_write(`CIA_REG_PRB, prb);
  wait_ticks(2);
  // Input bits float high
  check_byte("pa_out", pa_out, pra | ~ddra);
  check_byte("pb_out", pb_out, prb | ~ddrb);
  pa_in = 8'($urandom);
  pb_in = 8'($urandom);
  bus_read(`CIA_REG_PRA, data);
  check_byte("db_out PRA", data, pa_in);
  bus_read(`CIA_REG_PRB, data);
  check_byte("db_out PRB", data, pb_in);
  check_byte("pc_n", {7'd0, pc_n}, 8'h00);
  wait_ticks(1);
  check_byte("pc_n", {7'd0, pc_n}, 8'h01);
endtask

task automatic timer_a_continuous();
  int unsigned n;
  int unsigned t0;
  logic [7:0]  hi1;
  logic [7:0]  lo1;
  logic [7:0]  hi2;
  logic [7:0]  lo2;
  logic [7:0]  icr;
  n = $urandom_range(32'h1ff, 32'h180);
  bus_read(`CIA_REG_ICR, icr);
  bus_write(`CIA_REG_TALO, n[7:0]);
  bus_write(`CIA_REG_TAHI, n[15:8]);
  bus_write(`CIA_REG_CRA, 8'h11);
  t0 = phi2_ticks;
  bus_read(`CIA_REG_TAHI, hi1);
  bus_read(`CIA_REG_TALO, lo1);
  // Sample again well below the 0x100 boundary
  wait_until_tick(t0 + n - 32'h60);
  bus_read(`CIA_REG_TAHI, hi2);
  bus_read(`CIA_REG_TALO, lo2);
  check_true(hi2 < hi1, "Timer A high byte did not fall between samples");
  check_true(lo2 < lo1, "Timer A low byte did not fall between samples");
  wait_until_tick(t0 + n + 4);
  bus_read(`CIA_REG_ICR, icr);
  check_byte("ICR", icr, 8'h01);
  bus_read(`CIA_REG_ICR, icr);
  check_byte("ICR", icr, 8'h00);
  bus_write(`CIA_REG_CRA, 8'h00);
endtask

task automatic timer_a_one_shot();
  int unsigned n;
  int unsigned t0;
  logic [7:0]  data;
  n = $urandom_range(48, 16);
  bus_read(`CIA_REG_ICR, data);
  bus_write(`CIA_REG_TALO, n[7:0]);
  bus_write(`CIA_REG_TAHI, n[15:8]);
  bus_write(`CIA_REG_CRA, 8'h19);
  t0 = phi2_ticks;
  wait_until_tick(t0 + n + 4);
  // Only run_mode left
  bus_read(`CIA_REG_CRA, data);
  check_byte("CRA", data, 8'h08);
  bus_read(`CIA_REG_ICR, data);
  check_byte("ICR", data, 8'h01);
  wait_ticks(n + 4);
  bus_read(`CIA_REG_ICR, data);
  check_byte("ICR", data, 8'h00);
endtask

task automatic timer_cascade();
  int unsigned n;
  int unsigned m;
  int unsigned t0;
  logic [7:0]  icr;
  n = $urandom_range(8, 4);
  m = $urandom_range(6, 3);
  bus_read(`CIA_REG_ICR, icr);
  bus_write(`CIA_REG_TALO, n[7:0]);
  bus_write(`CIA_REG_TAHI, n[15:8]);
  bus_write(`CIA_REG_TBLO, m[7:0]);
  bus_write(`CIA_REG_TBHI, m[15:8]);
  // Timer B counts timer A underflows
  bus_write(`CIA_REG_CRB, 8'h51);
  bus_write(`CIA_REG_CRA, 8'h11);
  t0 = phi2_ticks;
  wait_until_tick(t0 + n * m - 3);
  bus_read(`CIA_REG_ICR, icr);
  check_byte("ICR bit 1", {7'd0, icr[1]}, 8'h00);
  wait_until_tick(t0 + n * m + 4);
  bus_read(`CIA_REG_ICR, icr);
  check_byte("ICR bit 1", {7'd0, icr[1]}, 8'h01);
  bus_write(`CIA_REG_CRA, 8'h00);
  bus_write(`CIA_REG_CRB, 8'h00);
endtask

task automatic irq_mask_flag();
  logic [7:0] icr;
  bus_read(`CIA_REG_ICR, icr);
  flag_n = 1'b0;
  wait_ticks(2);
  check_byte("irq_n", {7'd0, irq_n}, 8'h01);
  bus_write(`CIA_REG_ICR, 8'h90);
  wait_ticks(2);
  check_byte("irq_n", {7'd0, irq_n}, 8'h00);
  bus_read(`CIA_REG_ICR, icr);
  check_byte("ICR", icr, 8'h90);
  wait_ticks(2);
  check_byte("irq_n", {7'd0, irq_n}, 8'h01);
  // Clear the FLAG mask bit before a fresh edge
  bus_write(`CIA_REG_ICR, 8'h10);
  flag_n = 1'b1;
  wait_ticks(2);
  flag_n = 1'b0;
  wait_ticks(2);
  check_byte("irq_n", {7'd0, irq_n}, 8'h01);
  bus_read(`CIA_REG_ICR, icr);
  check_byte("ICR", icr, 8'h10);
  flag_n = 1'b1;
endtask

task automatic pb6_toggle();
  int unsigned n;
  int unsigned t0;
  int unsigned k;
  n = $urandom_range(16, 8);
  bus_write(`CIA_REG_DDRB, 8'hff);
  bus_write(`CIA_REG_PRB, 8'h00);
  bus_write(`CIA_REG_TALO, n[7:0]);
  bus_write(`CIA_REG_TAHI, n[15:8]);
  wait_ticks(2);
  check_byte("pb_out[6]", {7'd0, pb_out[6]}, 8'h00);
  bus_write(`CIA_REG_CRA, 8'h17);
  t0 = phi2_ticks;
  // Midpoints between underflows
  for (k = 0; k < 4; k++) begin
    wait_until_tick(t0 + n / 2 + k * n);
    check_byte("pb_out[6]", {7'd0, pb_out[6]}, {7'd0, ~k[0]});
  end
  bus_write(`CIA_REG_CRA, 8'h00);
endtask

// File: verif/cia_tb.sv
// CIA testbench top
// Clock, phi2 strobes, DUT, bus access and check tasks,
// cycle limit and final report
`timescale 1ns/100ps
`include "cia_macros.svh"

module cia_tb;

  // Clks per test, sized for the largest random latch values
  localparam int unsigned PORT_CLKS    = 60;
  localparam int unsigned CONT_CLKS    = 1100;
  localparam int unsigned ONESHOT_CLKS = 260;
  localparam int unsigned CASCADE_CLKS = 160;
  localparam int unsigned IRQ_CLKS     = 80;
  localparam int unsigned TOGGLE_CLKS  = 160;
  localparam int unsigned TIMEOUT_CLKS = 2 * (5 + PORT_CLKS + CONT_CLKS + ONESHOT_CLKS
                                              + CASCADE_CLKS + IRQ_CLKS + TOGGLE_CLKS);

  logic        clk;
  logic        int_reset;
  logic        phi2_p;
  logic        phi2_n;
  logic        cs_n;
  logic        rw;
  logic [3:0]  rs;
  logic [7:0]  db_in;
  logic [7:0]  db_out;
  logic [7:0]  pa_in;
  logic [7:0]  pa_out;
  logic [7:0]  pb_in;
  logic [7:0]  pb_out;
  logic        flag_n;
  logic        pc_n;
  logic        cnt_in;
  logic        irq_n;
  int unsigned phi2_ticks;
  int unsigned cycle_count;
  int unsigned checks;
  int unsigned errors;

  cia_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // phi2_p and phi2_n on alternate clks, ticks count sampled phi2_p
  always @(posedge clk) begin
    if (phi2_p) begin
      phi2_ticks++;
    end
    #10;
    phi2_n = phi2_p;
    phi2_p = ~phi2_p;
  end

  always @(posedge clk) begin
    cycle_count++;
  end

  initial begin
    wait (cycle_count >= TIMEOUT_CLKS);
    $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CLKS);
    $display("sim failed");
    $finish;
  end

  task automatic check_byte(input string name, input logic [7:0] got,
                            input logic [7:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("%s", what);
    end
  endtask

  task automatic wait_until_tick(input int unsigned t);
    while (phi2_ticks < t) begin
      @(posedge clk);
      #10;
    end
  endtask

  task automatic wait_ticks(input int unsigned n);
    wait_until_tick(phi2_ticks + n);
  endtask

  // Access lines held over one phi2_n clk
  task automatic bus_write(input logic [3:0] addr, input logic [7:0] data);
    @(posedge clk);
    if (phi2_n) begin
      @(posedge clk);
    end
    #10;
    cs_n  = 1'b0;
    rw    = 1'b0;
    rs    = addr;
    db_in = data;
    @(posedge clk);
    #10;
    cs_n = 1'b1;
    rw   = 1'b1;
  endtask

  task automatic bus_read(input logic [3:0] addr, output logic [7:0] data);
    @(posedge clk);
    if (phi2_n) begin
      @(posedge clk);
    end
    #10;
    cs_n = 1'b0;
    rw   = 1'b1;
    rs   = addr;
    @(posedge clk);
    #10;
    cs_n = 1'b1;
    data = db_out;
  endtask

  `include "cia_tests.svh"

  initial begin
    int_reset   = 1'b1;
    phi2_p      = 1'b0;
    phi2_n      = 1'b0;
    cs_n        = 1'b1;
    rw          = 1'b1;
    rs          = 4'h0;
    db_in       = 8'h00;
    pa_in       = 8'hff;
    pb_in       = 8'hff;
    flag_n      = 1'b1;
    cnt_in      = 1'b0;
    phi2_ticks  = 0;
    cycle_count = 0;
    checks      = 0;
    errors      = 0;
    void'($urandom(32'h3765));
    repeat (5) @(posedge clk);
    #10;
    int_reset = 1'b0;
    port_io();
    timer_a_continuous();
    timer_a_one_shot();
    timer_cascade();
    irq_mask_flag();
    pb6_toggle();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: rtl/cia_top.sv
// CIA top level
// Register block, timers A and B, interrupt controller
`timescale 1ns/100ps

module cia_top (
  input  logic       clk,
  input  logic       int_reset,
  input  logic       phi2_p,
  input  logic       phi2_n,
  input  logic       cs_n,
  input  logic       rw,
  input  logic [3:0] rs,
  input  logic [7:0] db_in,
  output logic [7:0] db_out,
  input  logic [7:0] pa_in,
  output logic [7:0] pa_out,
  input  logic [7:0] pb_in,
  output logic [7:0] pb_out,
  input  logic       flag_n,
  output logic       pc_n,
  input  logic       cnt_in,
  output logic       irq_n
);
  import cia_bus_pkg::*;
  import cia_timer_pkg::*;

  timer_stat_t ta_stat;
  timer_stat_t tb_stat;
  timer_wr_t   ta_wr;
  timer_wr_t   tb_wr;
  icr_write_t  icr_wr;
  icr_word_u   icr_status;
  irq_src_t    irq_src;
  logic        icr_rd;
  logic        ta_tick;
  logic        tb_tick;

  // No TOD alarm or serial port here, FLAG is detected in the controller
  assign irq_src = '{flag: 1'b0, serial: 1'b0, alarm: 1'b0,
                     tb: tb_stat.underflow, ta: ta_stat.underflow};

  cia_bus_regs u_regs (
    .clk        (clk),
    .int_reset  (int_reset),
    .phi2_p     (phi2_p),
    .phi2_n     (phi2_n),
    .cs_n       (cs_n),
    .rw         (rw),
    .rs         (rs),
    .db_in      (db_in),
    .pa_in      (pa_in),
    .pb_in      (pb_in),
    .cnt_in     (cnt_in),
    .ta_stat    (ta_stat),
    .tb_stat    (tb_stat),
    .icr_status (icr_status),
    .db_out     (db_out),
    .pa_out     (pa_out),
    .pb_out     (pb_out),
    .pc_n       (pc_n),
    .ta_wr      (ta_wr),
    .tb_wr      (tb_wr),
    .icr_wr     (icr_wr),
    .icr_rd     (icr_rd),
    .ta_tick    (ta_tick),
    .tb_tick    (tb_tick)
  );

  cia_timer u_timer_a (
    .clk        (clk),
    .int_reset  (int_reset),
    .phi2_p     (phi2_p),
    .wr         (ta_wr),
    .count_tick (ta_tick),
    .stat       (ta_stat)
  );

  cia_timer u_timer_b (
    .clk        (clk),
    .int_reset  (int_reset),
    .phi2_p     (phi2_p),
    .wr         (tb_wr),
    .count_tick (tb_tick),
    .stat       (tb_stat)
  );

  cia_irq_ctrl u_irq (
    .clk       (clk),
    .int_reset (int_reset),
    .phi2_p    (phi2_p),
    .src       (irq_src),
    .flag_n    (flag_n),
    .icr_wr    (icr_wr),
    .icr_rd    (icr_rd),
    .status    (icr_status),
    .irq_n     (irq_n)
  );

endmodule

// File: rtl/cia_irq_ctrl.sv
// Interrupt controller
// Flag and mask registers, FLAG pin edge detect, clear on ICR read, irq_n
`timescale 1ns/100ps

module cia_irq_ctrl (
  input  logic                    clk,
  input  logic                    int_reset,
  input  logic                    phi2_p,
  input  cia_bus_pkg::irq_src_t   src,
  input  logic                    flag_n,
  input  cia_bus_pkg::icr_write_t icr_wr,
  input  logic                    icr_rd,
  output cia_bus_pkg::icr_word_u  status,
  output logic                    irq_n
);
  import cia_bus_pkg::*;

  logic [4:0] flags;
  logic [4:0] mask;
  logic       flag_prev;
  logic       clr_pend;
  logic       pending;
  irq_src_t   events;

  // FLAG falling edge, sampled on phi2
  always_comb begin
    events      = src;
    events.flag = src.flag | (phi2_p & flag_prev & ~flag_n);
  end

  always_comb begin
    status.rd.irq   = ~irq_n;
    status.rd.zero  = 2'b00;
    status.rd.flags = flags;
  end

  assign pending = |(status.rd.flags & mask);

  always_ff @(posedge clk) begin
    if (int_reset) begin
      flags     <= 5'h00;
      mask      <= 5'h00;
      flag_prev <= 1'b1;
      clr_pend  <= 1'b0;
      irq_n     <= 1'b1;
    end else begin
      if (icr_wr.valid) begin
        mask <= icr_wr.word.wr.set_clr ? (mask | icr_wr.word.wr.sel)
                                       : (mask & ~icr_wr.word.wr.sel);
      end
      if (icr_rd) begin
        clr_pend <= 1'b1;
      end
      if (phi2_p) begin
        flag_prev <= flag_n;
      end
      // New events win over the read clear
      if (phi2_p && clr_pend) begin
        flags    <= events;
        irq_n    <= 1'b1;
        clr_pend <= 1'b0;
      end else begin
        flags <= flags | events;
        if (phi2_p && pending) begin
          irq_n <= 1'b0;
        end
      end
    end
  end

endmodule

// File: rtl/cia_timer.sv
// 16-bit interval timer
// Latch, down-counter, reload on underflow, force load,
// one-shot stop and PB toggle flip-flop
`timescale 1ns/100ps
`include "cia_macros.svh"

module cia_timer (
  input  logic                       clk,
  input  logic                       int_reset,
  input  logic                       phi2_p,
  input  cia_timer_pkg::timer_wr_t   wr,
  input  logic                       count_tick,
  output cia_timer_pkg::timer_stat_t stat
);
  import cia_timer_pkg::*;

  logic [15:0] latch;
  logic [15:0] count;
  logic [15:0] count_dec;
  timer_ctrl_t ctrl;
  timer_ctrl_t ctrl_new;
  logic        toggle;
  logic        load_pend;
  logic        underflow;

  assign count_dec = count - 16'd1;
  assign ctrl_new  = timer_ctrl_t'(wr.data);

  // Reaching zero reloads instead, so latch N gives a period of N ticks
  assign underflow = count_tick & ctrl.start & (count_dec == 16'd0);

  always_ff @(posedge clk) begin
    if (int_reset) begin
      latch     <= `CIA_LATCH_RESET;
      count     <= 16'h0000;
      ctrl      <= '0;
      toggle    <= 1'b0;
      load_pend <= 1'b0;
    end else begin
      if (underflow) begin
        count  <= latch;
        toggle <= ~toggle;
        if (ctrl.run_mode) begin
          ctrl.start <= 1'b0;
        end
      end else if (count_tick && ctrl.start) begin
        count <= count_dec;
      end

      // Force load takes effect on the phi2 edge after the write
      if (phi2_p && load_pend) begin
        count     <= latch;
        load_pend <= 1'b0;
      end

      if (wr.lo_wr) begin
        latch[7:0] <= wr.data;
      end
      if (wr.hi_wr) begin
        latch[15:8] <= wr.data;
        if (!ctrl.start) begin
          count <= {wr.data, latch[7:0]};
        end
      end
      if (wr.ctrl_wr) begin
        ctrl            <= ctrl_new;
        ctrl.force_load <= 1'b0;
        load_pend       <= ctrl_new.force_load;
        if (ctrl_new.start && !ctrl.start) begin
          toggle <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    stat.count     = count;
    stat.underflow = underflow;
    stat.toggle    = toggle;
    stat.ctrl      = ctrl;
  end

endmodule

// File: rtl/cia_bus_regs.sv
// CPU bus decoder and register block
// Port and DDR registers, registered read mux, PC strobe,
// PB6/PB7 timer outputs and count source selection
`timescale 1ns/100ps
`include "cia_macros.svh"

module cia_bus_regs (
  input  logic                       clk,
  input  logic                       int_reset,
  input  logic                       phi2_p,
  input  logic                       phi2_n,
  input  logic                       cs_n,
  input  logic                       rw,
  input  logic [3:0]                 rs,
  input  logic [7:0]                 db_in,
  input  logic [7:0]                 pa_in,
  input  logic [7:0]                 pb_in,
  input  logic                       cnt_in,
  input  cia_timer_pkg::timer_stat_t ta_stat,
  input  cia_timer_pkg::timer_stat_t tb_stat,
  input  cia_bus_pkg::icr_word_u     icr_status,
  output logic [7:0]                 db_out,
  output logic [7:0]                 pa_out,
  output logic [7:0]                 pb_out,
  output logic                       pc_n,
  output cia_timer_pkg::timer_wr_t   ta_wr,
  output cia_timer_pkg::timer_wr_t   tb_wr,
  output cia_bus_pkg::icr_write_t    icr_wr,
  output logic                       icr_rd,
  output logic                       ta_tick,
  output logic                       tb_tick
);
  import cia_timer_pkg::*;

  logic       rd;
  logic       wr;
  logic [7:0] pra;
  logic [7:0] prb;
  logic [7:0] ddra;
  logic [7:0] ddrb;
  logic [7:0] pb_next;
  logic       cnt_prev;
  logic       cnt_rise;

  // Pulse or toggle level that a timer puts on its PB pin
  function automatic logic timer_pb(timer_stat_t st);
    return st.ctrl.out_mode ? (st.toggle ^ st.underflow) : st.underflow;
  endfunction

  assign rd = phi2_n & ~cs_n & rw;
  assign wr = phi2_n & ~cs_n & ~rw;

  assign icr_rd = rd && (rs == `CIA_REG_ICR);

  always_comb begin
    ta_wr.lo_wr   = wr && (rs == `CIA_REG_TALO);
    ta_wr.hi_wr   = wr && (rs == `CIA_REG_TAHI);
    ta_wr.ctrl_wr = wr && (rs == `CIA_REG_CRA);
    ta_wr.data    = db_in;
    tb_wr.lo_wr   = wr && (rs == `CIA_REG_TBLO);
    tb_wr.hi_wr   = wr && (rs == `CIA_REG_TBHI);
    tb_wr.ctrl_wr = wr && (rs == `CIA_REG_CRB);
    tb_wr.data    = db_in;
    icr_wr.valid  = wr && (rs == `CIA_REG_ICR);
    icr_wr.word   = db_in;
  end

  // Count sources qualified by phi2_p
  assign cnt_rise = cnt_in & ~cnt_prev;
  assign ta_tick  = phi2_p & ((ta_stat.ctrl.in_mode == 2'd0) | cnt_rise);

  always_comb begin
    case (tb_stat.ctrl.in_mode)
      2'd0:    tb_tick = phi2_p;
      2'd1:    tb_tick = phi2_p & cnt_rise;
      default: tb_tick = phi2_p & ta_stat.underflow;
    endcase
  end

  always_comb begin
    pb_next = prb | ~ddrb;
    if (ta_stat.ctrl.pb_on) begin
      pb_next[6] = timer_pb(ta_stat);
    end
    if (tb_stat.ctrl.pb_on) begin
      pb_next[7] = timer_pb(tb_stat);
    end
  end

  always_ff @(posedge clk) begin
    if (int_reset) begin
      pra      <= 8'h00;
      prb      <= 8'h00;
      ddra     <= 8'h00;
      ddrb     <= 8'h00;
      pa_out   <= 8'hff;
      pb_out   <= 8'hff;
      pc_n     <= 1'b1;
      cnt_prev <= 1'b0;
      db_out   <= 8'h00;
    end else begin
      if (wr) begin
        case (rs)
          `CIA_REG_PRA:  pra  <= db_in;
          `CIA_REG_PRB:  prb  <= db_in;
          `CIA_REG_DDRA: ddra <= db_in;
          `CIA_REG_DDRB: ddrb <= db_in;
          default: ;
        endcase
      end
      if (rd) begin
        case (rs)
          `CIA_REG_PRA:  db_out <= pa_in;
          `CIA_REG_PRB:  db_out <= pb_in;
          `CIA_REG_DDRA: db_out <= ddra;
          `CIA_REG_DDRB: db_out <= ddrb;
          `CIA_REG_TALO: db_out <= ta_stat.count[7:0];
          `CIA_REG_TAHI: db_out <= ta_stat.count[15:8];
          `CIA_REG_TBLO: db_out <= tb_stat.count[7:0];
          `CIA_REG_TBHI: db_out <= tb_stat.count[15:8];
          `CIA_REG_ICR:  db_out <= icr_status;
          `CIA_REG_CRA:  db_out <= ta_stat.ctrl;
          `CIA_REG_CRB:  db_out <= tb_stat.ctrl;
          default:       db_out <= 8'h00;
        endcase
      end
      if (phi2_p) begin
        pa_out   <= pra | ~ddra;
        pb_out   <= pb_next;
        cnt_prev <= cnt_in;
      end
      // Handshake low until the next phi2 rising edge
      if ((rd || wr) && (rs == `CIA_REG_PRB)) begin
        pc_n <= 1'b0;
      end else if (phi2_p) begin
        pc_n <= 1'b1;
      end
    end
  end

endmodule

// File: rtl/cia_timer_pkg.sv
// Timer types
// Control register layout, write strobes from the bus, timer status
package cia_timer_pkg;

  typedef struct packed {
    logic       spare;
    logic [1:0] in_mode;
    logic       force_load;
    logic       run_mode;
    logic       out_mode;
    logic       pb_on;
    logic       start;
  } timer_ctrl_t;

  typedef struct packed {
    logic       lo_wr;
    logic       hi_wr;
    logic       ctrl_wr;
    logic [7:0] data;
  } timer_wr_t;

  typedef struct packed {
    logic [15:0] count;
    logic        underflow;
    logic        toggle;
    timer_ctrl_t ctrl;
  } timer_stat_t;

endpackage

// File: rtl/cia_bus_pkg.sv
// Bus side types
// ICR word with its status and mask views, mask write, interrupt sources
package cia_bus_pkg;

  // Read view of the ICR
  typedef struct packed {
    logic       irq;
    logic [1:0] zero;
    logic [4:0] flags;
  } icr_status_t;

  // Write view, bit 7 selects set or clear
  typedef struct packed {
    logic       set_clr;
    logic [1:0] unused;
    logic [4:0] sel;
  } icr_mask_t;

  typedef union packed {
    icr_status_t rd;
    icr_mask_t   wr;
  } icr_word_u;

  typedef struct packed {
    logic      valid;
    icr_word_u word;
  } icr_write_t;

  typedef struct packed {
    logic flag;
    logic serial;
    logic alarm;
    logic tb;
    logic ta;
  } irq_src_t;

endpackage

// File: rtl/cia_macros.svh
// Register select addresses for the CPU bus
// Reset value of the timer latches
`ifndef CIA_MACROS_SVH
`define CIA_MACROS_SVH

`define CIA_REG_PRA  4'h0
`define CIA_REG_PRB  4'h1
`define CIA_REG_DDRA 4'h2
`define CIA_REG_DDRB 4'h3
`define CIA_REG_TALO 4'h4
`define CIA_REG_TAHI 4'h5
`define CIA_REG_TBLO 4'h6
`define CIA_REG_TBHI 4'h7
`define CIA_REG_ICR  4'hd
`define CIA_REG_CRA  4'he
`define CIA_REG_CRB  4'hf

`define CIA_LATCH_RESET 16'hffff

`endif
